/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_exec
FILELIST  = all.f
LOG       = sim.log
PASS_MSG  = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_ifaces.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_exec.sv
hw/rv_exec_top.sv
tb/tb_rv_exec.sv

/* hw/rv_core_pkg.sv */
`default_nettype none

`include "rv_config.svh"

package rv_core_pkg;

  typedef logic [`XLEN-1:0] xword_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // Operations the ALU can perform
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // How the next PC is formed
  typedef enum logic [2:0] {
    FLOW_SEQ,
    FLOW_JAL,
    FLOW_JALR,
    FLOW_BR
  } flow_e;

  // Branch conditions, compared on rs1 and rs2
  typedef enum logic [2:0] {
    CMP_EQ,
    CMP_NE,
    CMP_LT,
    CMP_GE,
    CMP_LTU,
    CMP_GEU
  } cmp_e;

endpackage

`default_nettype wire

/* hw/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instr_vld,
  input  rv_isa_pkg::rv_instr_u instr,
  output logic                  illegal,
  uop_if.producer               uop
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [2:0] f3;
  logic [6:0] f7;
  xword_t     imm_i;
  xword_t     imm_b;
  xword_t     imm_u;
  xword_t     imm_j;

  logic       dec_legal;
  alu_op_e    dec_alu_op;
  flow_e      dec_flow;
  cmp_e       dec_cmp;
  logic       dec_rd_wr;
  xword_t     dec_imm;
  logic       dec_use_imm;
  logic       dec_use_pc;

  assign f3 = instr.r_fmt.funct3;
  assign f7 = instr.r_fmt.funct7;

  // ######################################################################
  // Immediates, one per format, all sign-extended from bit 31
  // ######################################################################

  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm31_12, 12'h000};
  assign imm_j = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                  instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};

  always_comb begin
    dec_legal   = 1'b1;
    dec_alu_op  = ALU_ADD;
    dec_flow    = FLOW_SEQ;
    dec_cmp     = CMP_EQ;
    dec_rd_wr   = 1'b1;
    dec_imm     = imm_i;
    dec_use_imm = 1'b0;
    dec_use_pc  = 1'b0;

    case (instr.r_fmt.opcode)
      OPC_OP: begin
        case (f3)
          F3_ADD:  dec_alu_op = (f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:  dec_alu_op = ALU_SLL;
          F3_SLT:  dec_alu_op = ALU_SLT;
          F3_SLTU: dec_alu_op = ALU_SLTU;
          F3_XOR:  dec_alu_op = ALU_XOR;
          F3_SR:   dec_alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:   dec_alu_op = ALU_OR;
          default: dec_alu_op = ALU_AND;
        endcase
        // Only ADD/SUB and SRL/SRA have an alternate funct7
        dec_legal = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR));
      end
      OPC_OP_IMM: begin
        dec_use_imm = 1'b1;
        case (f3)
          F3_ADD:  dec_alu_op = ALU_ADD;
          F3_SLT:  dec_alu_op = ALU_SLT;
          F3_SLTU: dec_alu_op = ALU_SLTU;
          F3_XOR:  dec_alu_op = ALU_XOR;
          F3_OR:   dec_alu_op = ALU_OR;
          F3_AND:  dec_alu_op = ALU_AND;
          F3_SLL: begin
            dec_alu_op = ALU_SLL;
            dec_legal  = (f7 == F7_BASE);
          end
          default: begin
            dec_alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            dec_legal  = (f7 == F7_BASE) || (f7 == F7_ALT);
          end
        endcase
      end
      OPC_LUI: begin
        dec_alu_op  = ALU_PASS_B;
        dec_imm     = imm_u;
        dec_use_imm = 1'b1;
      end
      OPC_AUIPC: begin
        dec_imm     = imm_u;
        dec_use_imm = 1'b1;
        dec_use_pc  = 1'b1;
      end
      OPC_JAL: begin
        dec_flow   = FLOW_JAL;
        dec_imm    = imm_j;
        dec_use_pc = 1'b1;
      end
      OPC_JALR: begin
        dec_flow   = FLOW_JALR;
        dec_use_pc = 1'b1;
        dec_legal  = (f3 == 3'b000);
      end
      OPC_BRANCH: begin
        dec_flow  = FLOW_BR;
        dec_imm   = imm_b;
        dec_rd_wr = 1'b0;
        case (f3)
          F3_BEQ:  dec_cmp = CMP_EQ;
          F3_BNE:  dec_cmp = CMP_NE;
          F3_BLT:  dec_cmp = CMP_LT;
          F3_BGE:  dec_cmp = CMP_GE;
          F3_BLTU: dec_cmp = CMP_LTU;
          F3_BGEU: dec_cmp = CMP_GEU;
          default: dec_legal = 1'b0;
        endcase
      end
      default: dec_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uop.vld <= 1'b0;
      illegal <= 1'b0;
    end else begin
      uop.vld <= instr_vld && dec_legal;
      illegal <= instr_vld && !dec_legal;
    end
  end

  always_ff @(posedge clk) begin
    uop.alu_op  <= dec_alu_op;
    uop.flow    <= dec_flow;
    uop.cmp     <= dec_cmp;
    uop.rs1     <= instr.r_fmt.rs1;
    uop.rs2     <= instr.r_fmt.rs2;
    uop.rd      <= instr.r_fmt.rd;
    // Writes to x0 are dropped here so nothing downstream sees them
    uop.rd_wr   <= dec_rd_wr && (instr.r_fmt.rd != '0);
    uop.imm     <= dec_imm;
    uop.use_imm <= dec_use_imm;
    uop.use_pc  <= dec_use_pc;
  end

  // Every strobe gives exactly one outcome one cycle later
  a_one_outcome: assert property (@(posedge clk) disable iff (rst)
    instr_vld |=> $onehot({illegal, uop.vld}));

endmodule

`default_nettype wire

/* hw/rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_exec (
  input  logic                  clk,
  input  logic                  rst,
  uop_if.consumer               uop,
  rf_if.client                  rf,
  output logic                  retire_vld,
  output rv_core_pkg::xword_t    retire_pc,
  output rv_core_pkg::xword_t    retire_next_pc,
  output logic                  retire_rd_wr,
  output rv_core_pkg::reg_addr_t retire_rd,
  output rv_core_pkg::xword_t    retire_rd_data
);
  import rv_core_pkg::*;

  localparam int SHAMT_W = $clog2(`XLEN);

  xword_t             pc_q;
  xword_t             seq_pc;
  logic               is_jump;
  xword_t             op_a;
  xword_t             op_b;
  logic [SHAMT_W-1:0] shamt;
  xword_t             alu_res;
  logic               br_taken;
  xword_t             tgt_base;
  xword_t             target;
  xword_t             next_pc;

  assign rf.rs1_addr = uop.rs1;
  assign rf.rs2_addr = uop.rs2;

  // ######################################################################
  // Operand select and ALU
  // ######################################################################

  assign is_jump = (uop.flow == FLOW_JAL) || (uop.flow == FLOW_JALR);

  // Jumps add PC_STEP to the PC so the ALU produces the link value
  assign op_a  = uop.use_pc ? pc_q : rf.rs1_data;
  assign op_b  = is_jump ? xword_t'(`PC_STEP) : (uop.use_imm ? uop.imm : rf.rs2_data);
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (uop.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_SLT:    alu_res = xword_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_res = xword_t'(op_a < op_b);
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLL:    alu_res = op_a << shamt;
      ALU_SRL:    alu_res = op_a >> shamt;
      ALU_SRA:    alu_res = xword_t'($signed(op_a) >>> shamt);
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // ######################################################################
  // Branch compare and next PC
  // ######################################################################

  always_comb begin
    case (uop.cmp)
      CMP_EQ:  br_taken = (rf.rs1_data == rf.rs2_data);
      CMP_NE:  br_taken = (rf.rs1_data != rf.rs2_data);
      CMP_LT:  br_taken = ($signed(rf.rs1_data) < $signed(rf.rs2_data));
      CMP_GE:  br_taken = ($signed(rf.rs1_data) >= $signed(rf.rs2_data));
      CMP_LTU: br_taken = (rf.rs1_data < rf.rs2_data);
      CMP_GEU: br_taken = (rf.rs1_data >= rf.rs2_data);
      default: br_taken = 1'b0;
    endcase
  end

  assign seq_pc   = pc_q + xword_t'(`PC_STEP);
  assign tgt_base = (uop.flow == FLOW_JALR) ? rf.rs1_data : pc_q;
  assign target   = tgt_base + uop.imm;

  always_comb begin
    case (uop.flow)
      FLOW_JAL:  next_pc = target;
      FLOW_JALR: next_pc = {target[`XLEN-1:1], 1'b0};
      FLOW_BR:   next_pc = br_taken ? target : seq_pc;
      default:   next_pc = seq_pc;
    endcase
  end

  // Write lands at the same edge the retire record is registered
  assign rf.wr      = uop.vld && uop.rd_wr;
  assign rf.wr_addr = uop.rd;
  assign rf.wr_data = alu_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q         <= xword_t'(`RESET_PC);
      retire_vld   <= 1'b0;
      retire_rd_wr <= 1'b0;
    end else begin
      retire_vld   <= uop.vld;
      retire_rd_wr <= uop.vld && uop.rd_wr;
      if (uop.vld) begin
        pc_q <= next_pc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (uop.vld) begin
      retire_pc      <= pc_q;
      retire_next_pc <= next_pc;
      retire_rd      <= uop.rd;
      retire_rd_data <= alu_res;
    end
  end

  // Holds only while every decoded branch and jump offset is even
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    retire_vld |-> !retire_next_pc[0]);

endmodule

`default_nettype wire

/* hw/rv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instr_vld,
  input  rv_core_pkg::xword_t    instr,
  output logic                   illegal,
  output logic                   retire_vld,
  output rv_core_pkg::xword_t    retire_pc,
  output rv_core_pkg::xword_t    retire_next_pc,
  output logic                   retire_rd_wr,
  output rv_core_pkg::reg_addr_t retire_rd,
  output rv_core_pkg::xword_t    retire_rd_data
);

  uop_if uop_bus ();
  rf_if  rf_bus ();

  // Decoder, one cycle from strobe to micro-op
  rv_decoder u_decoder (
    .clk       (clk),
    .rst       (rst),
    .instr_vld (instr_vld),
    .instr     (instr),
    .illegal   (illegal),
    .uop       (uop_bus.producer)
  );

  rv_regfile u_regfile (
    .clk (clk),
    .rst (rst),
    .rf  (rf_bus.server)
  );

  rv_exec u_exec (
    .clk            (clk),
    .rst            (rst),
    .uop            (uop_bus.consumer),
    .rf             (rf_bus.client),
    .retire_vld     (retire_vld),
    .retire_pc      (retire_pc),
    .retire_next_pc (retire_next_pc),
    .retire_rd_wr   (retire_rd_wr),
    .retire_rd      (retire_rd),
    .retire_rd_data (retire_rd_data)
  );

endmodule

`default_nettype wire

/* hw/rv_ifaces.sv */
`timescale 1ns/1ps
`default_nettype none

// Micro-op from decoder to executor, vld is a single-cycle strobe
interface uop_if;
  import rv_core_pkg::*;

  logic      vld;
  alu_op_e   alu_op;
  flow_e     flow;
  cmp_e      cmp;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      rd_wr;
  xword_t    imm;
  logic      use_imm;
  logic      use_pc;

  modport producer (
    output vld, alu_op, flow, cmp, rs1, rs2, rd, rd_wr, imm, use_imm, use_pc
  );

  modport consumer (
    input vld, alu_op, flow, cmp, rs1, rs2, rd, rd_wr, imm, use_imm, use_pc
  );
endinterface

// Register file access with combinational reads and one write port
interface rf_if;
  import rv_core_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xword_t    rs1_data;
  xword_t    rs2_data;
  logic      wr;
  reg_addr_t wr_addr;
  xword_t    wr_data;

  modport client (
    output rs1_addr, rs2_addr, wr, wr_addr, wr_data,
    input  rs1_data, rs2_data
  );

  modport server (
    input  rs1_addr, rs2_addr, wr, wr_addr, wr_data,
    output rs1_data, rs2_data
  );
endinterface

`default_nettype wire

/* hw/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // Minor codes of the OP and OP_IMM groups
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  // Branch conditions reuse the funct3 field with their own meaning
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } funct7_e;

  // ######################################################################
  // Instruction formats, all views of the same 32-bit word
  // ######################################################################

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } rv_instr_u;

endpackage

`default_nettype wire

/* hw/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_regfile (
  input  logic  clk,
  input  logic  rst,
  rf_if.server  rf
);
  import rv_core_pkg::*;

  xword_t regs [`NUM_REGS];

  // x0 stays zero because it is cleared on reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr && rf.wr_addr != '0) begin
      regs[rf.wr_addr] <= rf.wr_data;
    end
  end

  assign rf.rs1_data = regs[rf.rs1_addr];
  assign rf.rs2_data = regs[rf.rs2_addr];

  a_x0_rs1: assert property (@(posedge clk) disable iff (rst)
    rf.rs1_addr == '0 |-> rf.rs1_data == '0);

  a_x0_rs2: assert property (@(posedge clk) disable iff (rst)
    rf.rs2_addr == '0 |-> rf.rs2_data == '0);

endmodule

`default_nettype wire

/* include/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// ######################################################################
// Core dimensions
// ######################################################################

// Data path and register width
`define XLEN 32

// Architectural register count and index width
`define NUM_REGS 32
`define REG_ADDR_W 5

// ######################################################################
// Program counter
// ######################################################################

// PC value after reset
`define RESET_PC 32'h0000_0000

// Sequential PC increment in bytes
`define PC_STEP 4

`endif

/* tb/tb_rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module tb_rv_exec;
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  typedef struct packed {
    int        cyc;
    xword_t    pc;
    xword_t    next_pc;
    logic      rd_wr;
    reg_addr_t rd;
    xword_t    data;
  } ret_rec_t;

  localparam int DRAIN_LIMIT = 40;

  logic      clk;
  logic      rst;
  logic      instr_vld;
  xword_t    instr;
  logic      illegal;
  logic      retire_vld;
  xword_t    retire_pc;
  xword_t    retire_next_pc;
  logic      retire_rd_wr;
  reg_addr_t retire_rd;
  xword_t    retire_rd_data;

  xword_t   mregs [`NUM_REGS];
  xword_t   mpc;
  ret_rec_t exp_ret [$];
  int       exp_ill [$];
  ret_rec_t got_rec;
  int       cycle_cnt;
  int       errors;
  int       test_errs;
  int       tests_run;
  int       tests_failed;

  rv_exec_top dut (
    .clk            (clk),
    .rst            (rst),
    .instr_vld      (instr_vld),
    .instr          (instr),
    .illegal        (illegal),
    .retire_vld     (retire_vld),
    .retire_pc      (retire_pc),
    .retire_next_pc (retire_next_pc),
    .retire_rd_wr   (retire_rd_wr),
    .retire_rd      (retire_rd),
    .retire_rd_data (retire_rd_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ####################################################################
  // Compare tasks
  // ####################################################################

  task automatic check_word(input string name, input xword_t got, input xword_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst && retire_vld) begin
      if (exp_ret.size() == 0) begin
        errors++;
        $display("Retire at pc %h with no instruction outstanding", retire_pc);
      end else begin
        got_rec = exp_ret.pop_front();
        if (cycle_cnt != got_rec.cyc + 2) begin
          errors++;
          $display("Retire of pc %h came %0d cycles after its strobe instead of 2",
                   retire_pc, cycle_cnt - got_rec.cyc);
        end
        check_word("retire_pc", retire_pc, got_rec.pc);
        check_word("retire_next_pc", retire_next_pc, got_rec.next_pc);
        check_flag("retire_rd_wr", retire_rd_wr, got_rec.rd_wr);
        if (got_rec.rd_wr) begin
          check_reg("retire_rd", retire_rd, got_rec.rd);
          check_word("retire_rd_data", retire_rd_data, got_rec.data);
        end
      end
    end
    if (!rst && illegal) begin
      if (exp_ill.size() == 0) begin
        errors++;
        $display("Illegal strobe raised for a legal instruction");
      end else if (cycle_cnt != exp_ill.pop_front() + 1) begin
        errors++;
        $display("Illegal strobe came at the wrong cycle");
      end
    end
  end

  // ####################################################################
  // Reference model, applied in issue order
  // ####################################################################

  task automatic model_step(input xword_t w);
    logic [2:0] f3;
    reg_addr_t  rd;
    xword_t     a;
    xword_t     b;
    xword_t     imm_i;
    xword_t     res;
    xword_t     npc;
    logic       legal;
    logic       wr;
    logic       taken;
    ret_rec_t   rec;
    f3     = w[14:12];
    rd     = w[11:7];
    a      = mregs[w[19:15]];
    b      = mregs[w[24:20]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    res    = '0;
    npc    = mpc + `PC_STEP;
    legal  = 1'b1;
    wr     = 1'b1;
    taken  = 1'b0;
    case (w[6:0])
      OPC_OP: begin
        legal = (w[31:25] == F7_BASE) || (w[31:25] == F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        res   = alu_ref(f3, w[30], a, b);
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          legal = (w[31:25] == F7_BASE);
        end else if (f3 == 3'd5) begin
          legal = (w[31:25] == F7_BASE) || (w[31:25] == F7_ALT);
        end
        res = alu_ref(f3, (f3 == 3'd5) && w[30], a, imm_i);
      end
      OPC_LUI:   res = {w[31:12], 12'h000};
      OPC_AUIPC: res = mpc + {w[31:12], 12'h000};
      OPC_JAL: begin
        res = mpc + `PC_STEP;
        npc = mpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR: begin
        legal = (f3 == 3'd0);
        res   = mpc + `PC_STEP;
        npc   = (a + imm_i) & ~32'h1;
      end
      OPC_BRANCH: begin
        wr = 1'b0;
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          3'd7:    taken = (a >= b);
          default: legal = 1'b0;
        endcase
        if (taken) begin
          npc = mpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      exp_ill.push_back(cycle_cnt);
    end else begin
      rec.cyc     = cycle_cnt;
      rec.pc      = mpc;
      rec.next_pc = npc;
      rec.rd_wr   = wr && (rd != 5'd0);
      rec.rd      = rd;
      rec.data    = res;
      exp_ret.push_back(rec);
      if (rec.rd_wr) begin
        mregs[rd] = res;
      end
      mpc = npc;
    end
  endtask

  function automatic xword_t alu_ref(input logic [2:0] f3, input logic alt,
                                     input xword_t a, input xword_t b);
    xword_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // ####################################################################
  // Instruction encoders and random generators
  // ####################################################################

  function automatic xword_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic xword_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xword_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic xword_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic xword_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Only x0..x7 so that back-to-back instructions often depend on each other
  function automatic reg_addr_t rand_reg();
    return reg_addr_t'($urandom_range(7, 0));
  endfunction

  function automatic xword_t rand_alu();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'($urandom_range(7, 0));
    alt = 1'($urandom_range(1, 0));
    imm = 12'($urandom);
    if ($urandom_range(1, 0) == 0) begin
      return enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? F7_ALT : F7_BASE,
                   rand_reg(), rand_reg(), f3, rand_reg(), OPC_OP);
    end
    if (f3 == 3'd1) begin
      imm = {7'h00, imm[4:0]};
    end else if (f3 == 3'd5) begin
      imm = {alt ? F7_ALT : F7_BASE, imm[4:0]};
    end
    return enc_i(imm, rand_reg(), f3, rand_reg(), OPC_OP_IMM);
  endfunction

  function automatic xword_t rand_flow();
    logic [2:0] f3;
    f3 = 3'($urandom_range(7, 0));
    if (f3 == 3'd2 || f3 == 3'd3) begin
      f3 = f3 + 3'd2;
    end
    case ($urandom_range(2, 0))
      0:       return enc_b({12'($urandom), 1'b0}, rand_reg(), rand_reg(), f3);
      1:       return enc_j({20'($urandom), 1'b0}, rand_reg());
      default: return enc_i(12'($urandom), rand_reg(), 3'd0, rand_reg(), OPC_JALR);
    endcase
  endfunction

  function automatic xword_t rand_upper();
    if ($urandom_range(1, 0) == 0) begin
      return enc_u(20'($urandom), rand_reg(), OPC_LUI);
    end
    return enc_u(20'($urandom), rand_reg(), OPC_AUIPC);
  endfunction

  function automatic xword_t rand_illegal();
    case ($urandom_range(4, 0))
      0: return enc_r(7'h01, rand_reg(), rand_reg(), 3'($urandom), rand_reg(), OPC_OP);
      1: return enc_i({F7_ALT, 5'($urandom)}, rand_reg(), F3_SLL, rand_reg(), OPC_OP_IMM);
      2: return enc_b({12'($urandom), 1'b0}, rand_reg(), rand_reg(), 3'd2);
      3: return enc_i(12'($urandom), rand_reg(), 3'd1, rand_reg(), OPC_JALR);
      // A load word, outside the supported subset
      default: return enc_i(12'($urandom), rand_reg(), 3'd2, rand_reg(), 7'h03);
    endcase
  endfunction

  // ####################################################################
  // Drivers and test bookkeeping
  // ####################################################################

  task automatic issue_word(input xword_t w);
    @(posedge clk);
    #1;
    instr_vld = 1'b1;
    instr     = w;
    model_step(w);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    instr_vld = 1'b0;
    while ((exp_ret.size() > 0 || exp_ill.size() > 0) && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_ret.size() > 0 || exp_ill.size() > 0) begin
      errors++;
      $display("Timed out with %0d retires and %0d illegal strobes still outstanding",
               exp_ret.size(), exp_ill.size());
      exp_ret.delete();
      exp_ill.delete();
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_errs) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", tests_run, name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  initial begin
    void'($urandom(32'he80439eb));
    clk       = 1'b0;
    rst       = 1'b1;
    instr_vld = 1'b0;
    instr     = '0;
    cycle_cnt = 0;
    errors    = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    mpc       = `RESET_PC;
    for (int i = 0; i < `NUM_REGS; i++) begin
      mregs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Negative immediate shows the sign extension
    issue_word(enc_i(12'hf85, 5'd1, F3_ADD, 5'd1, OPC_OP_IMM));
    wait_drain();
    report_test("reset_addi");

    for (int i = 0; i < 300; i++) begin
      issue_word(rand_alu());
    end
    wait_drain();
    report_test("alu_stream");

    issue_word(enc_i(12'h101, 5'd0, F3_ADD, 5'd5, OPC_OP_IMM));
    issue_word(enc_i(12'h010, 5'd5, 3'd0, 5'd0, OPC_JALR));
    issue_word(enc_j(21'h000010, 5'd0));
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(2, 0) == 0) begin
        issue_word(rand_alu());
      end else begin
        issue_word(rand_flow());
      end
    end
    wait_drain();
    report_test("branch_jump");

    for (int i = 0; i < 120; i++) begin
      if ($urandom_range(1, 0) == 0) begin
        issue_word(rand_upper());
      end else begin
        issue_word(enc_b({12'($urandom), 1'b0}, rand_reg(), rand_reg(), 3'd0));
      end
    end
    wait_drain();
    report_test("upper_imm");

    for (int i = 0; i < 30; i++) begin
      issue_word(rand_illegal());
      if ($urandom_range(1, 0) == 0) begin
        issue_word(rand_illegal());
      end
      issue_word(enc_u(20'($urandom), rand_reg(), OPC_AUIPC));
      issue_word(enc_i(12'h000, rand_reg(), F3_OR, rand_reg(), OPC_OP_IMM));
    end
    wait_drain();
    report_test("illegal");

    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
